//--- src/imsic_defs.svh
// sizes for the imsic block; XLEN is 64 only and IMSIC_FILE_W must cover IMSIC_NR_FILES
`ifndef IMSIC_DEFS_SVH
`define IMSIC_DEFS_SVH

// file 0 is machine, file 1 supervisor, the rest are guest files
`define IMSIC_NR_FILES 4

// one eip/eie pair per file at this width
`define IMSIC_XLEN 64

// identities per file, id 0 reserved
`define IMSIC_NR_IDS `IMSIC_XLEN

// width of a file index
`define IMSIC_FILE_W 2

`endif

//--- src/imsic_csr_pkg.sv
// csr address layout for the imsic interrupt file window; covers eip0/eie0 only at XLEN 64
`default_nettype none

package imsic_csr_pkg;

    // one address word, read either whole or as page/index/odd fields
    typedef union packed {
        logic [11:0] raw;          // exact match for the config registers
        struct packed {
            logic [5:0] page;      // upper six bits select eip or eie
            logic [4:0] idx;       // register index inside the page
            logic       odd;       // odd halves are illegal at XLEN 64
        } f;
    } csr_addr_u;

    typedef enum logic [2:0] {
        REG_IPRIO,
        REG_EIDELIVERY,
        REG_EITHRESHOLD,
        REG_EIP,
        REG_EIE,
        REG_NONE
    } csr_region_e;

    localparam logic [11:0] EIDELIVERY_ADDR  = 12'h070;
    localparam logic [11:0] EITHRESHOLD_ADDR = 12'h072;

    // iprio window 0x30..0x3f, matched on the upper byte of the address
    localparam logic [7:0]  PAGE_IPRIO = 8'h03;
    localparam logic [5:0]  PAGE_EIP   = 6'h02;   // 0x80 >> 6
    localparam logic [5:0]  PAGE_EIE   = 6'h03;   // 0xc0 >> 6

endpackage

`default_nettype wire

//--- src/imsic_file_pkg.sv
// datapath types shared by the imsic blocks; topei priority always equals the identity
`default_nettype none

`include "imsic_defs.svh"

package imsic_file_pkg;

    // selects one interrupt file
    typedef logic [`IMSIC_FILE_W-1:0] file_idx_t;

    // identity number, 1 to 63 usable
    typedef logic [5:0] intr_id_t;

    // one eip or eie word
    typedef logic [`IMSIC_XLEN-1:0] xlen_t;

    // identity in 26:16, priority in 10:0
    typedef logic [31:0] topei_t;

    // packs an identity into a topei word
    function automatic topei_t make_topei(input intr_id_t id);
        topei_t word;
        word        = '0;
        word[26:16] = 11'(id);
        word[10:0]  = 11'(id);  // priority follows the identity
        return word;
    endfunction

endpackage

`default_nettype wire

//--- src/imsic_csr_access.sv
// csr channel of the imsic; i_csr_file must be below IMSIC_NR_FILES, one response held at most
`default_nettype none

`include "imsic_defs.svh"

module imsic_csr_access (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          i_csr_vld,
    input  wire                          i_csr_we,
    input  imsic_csr_pkg::csr_addr_u     i_csr_addr,
    input  imsic_file_pkg::xlen_t        i_csr_wdata,
    input  imsic_file_pkg::file_idx_t    i_csr_file,
    input  wire                          i_csr_v,
    input  wire                          i_csr_priv_err,
    input  wire                          i_rsp_ready,
    input  imsic_file_pkg::xlen_t        i_eip [`IMSIC_NR_FILES],
    output logic                         o_csr_ready,
    output logic                         o_rsp_vld,
    output imsic_file_pkg::xlen_t        o_rsp_rdata,
    output logic                         o_rsp_illegal,
    output logic                         o_eip_wr,
    output imsic_file_pkg::file_idx_t    o_eip_wr_file,
    output imsic_file_pkg::xlen_t        o_eip_wr_data,
    output imsic_file_pkg::xlen_t        o_eie [`IMSIC_NR_FILES],
    output imsic_file_pkg::intr_id_t     o_eithreshold [`IMSIC_NR_FILES],
    output logic [`IMSIC_NR_FILES-1:0]   o_eidelivery
);

    import imsic_csr_pkg::*;
    import imsic_file_pkg::*;

    csr_region_e region;
    logic        illegal;
    logic        acc;       // request taken this edge
    logic        wr_ok;     // legal write taken this edge
    xlen_t       rd_data;

    // a new request only when the response slot is free or draining
    assign o_csr_ready = !o_rsp_vld || i_rsp_ready;
    assign acc         = i_csr_vld && o_csr_ready;

    // exact match first, then the field view of the same address
    always_comb begin
        if (i_csr_addr.raw == EIDELIVERY_ADDR) begin
            region = REG_EIDELIVERY;
        end else if (i_csr_addr.raw == EITHRESHOLD_ADDR) begin
            region = REG_EITHRESHOLD;
        end else if (i_csr_addr.raw[11:4] == PAGE_IPRIO) begin
            region = REG_IPRIO;
        end else if (i_csr_addr.f.page == PAGE_EIP) begin
            region = REG_EIP;
        end else if (i_csr_addr.f.page == PAGE_EIE) begin
            region = REG_EIE;
        end else begin
            region = REG_NONE;
        end
    end

    always_comb begin
        illegal = i_csr_priv_err;
        case (region)
            REG_IPRIO: begin
                illegal = illegal || i_csr_v || i_csr_addr.f.odd;  // no iprio in virtual mode
            end
            REG_EIP, REG_EIE: begin
                illegal = illegal || i_csr_addr.f.odd || (i_csr_addr.f.idx != 5'd0);
            end
            REG_NONE: begin
                illegal = 1'b1;
            end
            default: ;
        endcase
    end

    assign wr_ok = acc && i_csr_we && !illegal;

    // read data from the state before this edge
    always_comb begin
        rd_data = '0;
        if (!i_csr_we && !illegal) begin
            case (region)
                REG_EIDELIVERY:  rd_data = xlen_t'(o_eidelivery[i_csr_file]);
                REG_EITHRESHOLD: rd_data = xlen_t'(o_eithreshold[i_csr_file]);
                REG_EIP:         rd_data = i_eip[i_csr_file];
                REG_EIE:         rd_data = o_eie[i_csr_file];
                default:         rd_data = '0;   // iprio reads zero
            endcase
        end
    end

    // eip lives in the pending block, only the strobe goes out
    assign o_eip_wr      = wr_ok && (region == REG_EIP);
    assign o_eip_wr_file = i_csr_file;
    assign o_eip_wr_data = {i_csr_wdata[`IMSIC_XLEN-1:1], 1'b0};  // id 0 never pending

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_eidelivery <= '0;
            for (int f = 0; f < `IMSIC_NR_FILES; f++) begin
                o_eie[f]         <= '0;
                o_eithreshold[f] <= '0;
            end
        end else if (wr_ok) begin
            case (region)
                REG_EIDELIVERY:  o_eidelivery[i_csr_file]  <= i_csr_wdata[0];
                REG_EITHRESHOLD: o_eithreshold[i_csr_file] <= i_csr_wdata[5:0];
                REG_EIE:         o_eie[i_csr_file]         <= i_csr_wdata;
                default: ;
            endcase
        end
    end

    // response slot, held until the consumer takes it
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_rsp_vld     <= 1'b0;
            o_rsp_rdata   <= '0;
            o_rsp_illegal <= 1'b0;
        end else if (acc) begin
            o_rsp_vld     <= 1'b1;
            o_rsp_rdata   <= rd_data;
            o_rsp_illegal <= illegal;
        end else if (i_rsp_ready) begin
            o_rsp_vld     <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/imsic_pending.sv
// pending words of all files; a software eip write stalls setipnum for that cycle
`default_nettype none

`include "imsic_defs.svh"

module imsic_pending (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          i_seteip_vld,
    input  imsic_file_pkg::file_idx_t    i_seteip_file,
    input  imsic_file_pkg::intr_id_t     i_seteip_num,
    input  wire                          i_eip_wr,
    input  imsic_file_pkg::file_idx_t    i_eip_wr_file,
    input  imsic_file_pkg::xlen_t        i_eip_wr_data,
    output logic                         o_seteip_ready,
    output imsic_file_pkg::xlen_t        o_eip [`IMSIC_NR_FILES]
);

    import imsic_file_pkg::*;

    logic [`IMSIC_NR_FILES-1:0] wr_hit;    // software write to this file
    logic [`IMSIC_NR_FILES-1:0] set_hit;   // msi sets a bit in this file
    logic                       seteip_acc;

    // software wins, msi waits one cycle
    assign o_seteip_ready = !i_eip_wr;
    assign seteip_acc     = i_seteip_vld && o_seteip_ready;

    always_comb begin
        for (int f = 0; f < `IMSIC_NR_FILES; f++) begin
            wr_hit[f]  = i_eip_wr && (i_eip_wr_file == file_idx_t'(f));
            set_hit[f] = seteip_acc
                      && (i_seteip_num != '0)           // id 0 dropped
                      && (i_seteip_file == file_idx_t'(f));
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int f = 0; f < `IMSIC_NR_FILES; f++) begin
                o_eip[f] <= '0;
            end
        end else begin
            for (int f = 0; f < `IMSIC_NR_FILES; f++) begin
                if (wr_hit[f]) begin
                    o_eip[f] <= i_eip_wr_data;          // whole word replaced
                end else if (set_hit[f]) begin
                    o_eip[f][i_seteip_num] <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/imsic_topei_select.sv
// top-interrupt search per file, results one cycle behind; vgein beyond the guest files gives zero
`default_nettype none

`include "imsic_defs.svh"

module imsic_topei_select (
    input  wire                          clk,
    input  wire                          rstn,
    input  imsic_file_pkg::xlen_t        i_eip [`IMSIC_NR_FILES],
    input  imsic_file_pkg::xlen_t        i_eie [`IMSIC_NR_FILES],
    input  imsic_file_pkg::intr_id_t     i_eithreshold [`IMSIC_NR_FILES],
    input  wire [`IMSIC_NR_FILES-1:0]    i_eidelivery,
    input  wire [5:0]                    i_vgein,
    output logic [2:0]                   o_irq,
    output imsic_file_pkg::topei_t       o_mtopei,
    output imsic_file_pkg::topei_t       o_stopei,
    output imsic_file_pkg::topei_t       o_vstopei
);

    import imsic_file_pkg::*;

    logic [`IMSIC_NR_FILES-1:0] found;
    intr_id_t                   top_id [`IMSIC_NR_FILES];
    logic                       guest_ok;
    file_idx_t                  guest;

    // scan from the top so the lowest hit is kept
    always_comb begin
        for (int f = 0; f < `IMSIC_NR_FILES; f++) begin
            found[f]  = 1'b0;
            top_id[f] = '0;
            for (int j = `IMSIC_NR_IDS - 1; j >= 1; j--) begin
                if (i_eip[f][j] && i_eie[f][j]
                    && ((i_eithreshold[f] == '0) || (j < i_eithreshold[f]))) begin
                    found[f]  = 1'b1;
                    top_id[f] = intr_id_t'(j);
                end
            end
        end
    end

    // guest files start at index 2
    assign guest_ok = i_vgein < 6'(`IMSIC_NR_FILES - 2);
    assign guest    = file_idx_t'(i_vgein + 6'd2);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_irq     <= '0;
            o_mtopei  <= '0;
            o_stopei  <= '0;
            o_vstopei <= '0;
        end else begin
            // line needs delivery, topei does not
            o_irq[0] <= found[0] && i_eidelivery[0];
            o_irq[1] <= found[1] && i_eidelivery[1];
            o_irq[2] <= guest_ok && found[guest] && i_eidelivery[guest];

            o_mtopei <= found[0] ? make_topei(top_id[0]) : '0;
            o_stopei <= found[1] ? make_topei(top_id[1]) : '0;
            if (guest_ok && found[guest]) begin
                o_vstopei <= make_topei(top_id[guest]);
            end else begin
                o_vstopei <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/imsic_top.sv
// imsic interrupt file block; XLEN 64, eip0/eie0 only, i_csr_file below IMSIC_NR_FILES
`default_nettype none

`include "imsic_defs.svh"

module imsic_top (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          i_csr_vld,
    input  wire                          i_csr_we,
    input  imsic_csr_pkg::csr_addr_u     i_csr_addr,
    input  imsic_file_pkg::xlen_t        i_csr_wdata,
    input  imsic_file_pkg::file_idx_t    i_csr_file,
    input  wire                          i_csr_v,
    input  wire                          i_csr_priv_err,
    output logic                         o_csr_ready,
    output logic                         o_rsp_vld,
    output imsic_file_pkg::xlen_t        o_rsp_rdata,
    output logic                         o_rsp_illegal,
    input  wire                          i_rsp_ready,
    input  wire                          i_seteip_vld,
    input  imsic_file_pkg::file_idx_t    i_seteip_file,
    input  imsic_file_pkg::intr_id_t     i_seteip_num,
    output logic                         o_seteip_ready,
    input  wire [5:0]                    i_vgein,
    output logic [2:0]                   o_irq,
    output imsic_file_pkg::topei_t       o_mtopei,
    output imsic_file_pkg::topei_t       o_stopei,
    output imsic_file_pkg::topei_t       o_vstopei
);

    import imsic_file_pkg::*;

    logic                       eip_wr;        // software eip write strobe
    file_idx_t                  eip_wr_file;
    xlen_t                      eip_wr_data;
    xlen_t                      eip [`IMSIC_NR_FILES];
    xlen_t                      eie [`IMSIC_NR_FILES];
    intr_id_t                   eithreshold [`IMSIC_NR_FILES];
    logic [`IMSIC_NR_FILES-1:0] eidelivery;

    imsic_csr_access u_csr (
        .clk            (clk),
        .rstn           (rstn),
        .i_csr_vld      (i_csr_vld),
        .i_csr_we       (i_csr_we),
        .i_csr_addr     (i_csr_addr),
        .i_csr_wdata    (i_csr_wdata),
        .i_csr_file     (i_csr_file),
        .i_csr_v        (i_csr_v),
        .i_csr_priv_err (i_csr_priv_err),
        .i_rsp_ready    (i_rsp_ready),
        .i_eip          (eip),
        .o_csr_ready    (o_csr_ready),
        .o_rsp_vld      (o_rsp_vld),
        .o_rsp_rdata    (o_rsp_rdata),
        .o_rsp_illegal  (o_rsp_illegal),
        .o_eip_wr       (eip_wr),
        .o_eip_wr_file  (eip_wr_file),
        .o_eip_wr_data  (eip_wr_data),
        .o_eie          (eie),
        .o_eithreshold  (eithreshold),
        .o_eidelivery   (eidelivery)
    );

    imsic_pending u_pending (
        .clk            (clk),
        .rstn           (rstn),
        .i_seteip_vld   (i_seteip_vld),
        .i_seteip_file  (i_seteip_file),
        .i_seteip_num   (i_seteip_num),
        .i_eip_wr       (eip_wr),
        .i_eip_wr_file  (eip_wr_file),
        .i_eip_wr_data  (eip_wr_data),
        .o_seteip_ready (o_seteip_ready),
        .o_eip          (eip)
    );

    imsic_topei_select u_topei (
        .clk            (clk),
        .rstn           (rstn),
        .i_eip          (eip),
        .i_eie          (eie),
        .i_eithreshold  (eithreshold),
        .i_eidelivery   (eidelivery),
        .i_vgein        (i_vgein),
        .o_irq          (o_irq),
        .o_mtopei       (o_mtopei),
        .o_stopei       (o_stopei),
        .o_vstopei      (o_vstopei)
    );

endmodule

`default_nettype wire

//--- tests/imsic_asserts.sv
// handshake and reset checks bound into imsic_top; clocked on the rising edge, n_fail counts hits
`default_nettype none

module imsic_asserts (
    input wire                    clk,
    input wire                    rstn,
    input wire                    i_csr_vld,
    input wire                    i_rsp_ready,
    input wire                    o_csr_ready,
    input wire                    o_rsp_vld,
    input imsic_file_pkg::xlen_t  o_rsp_rdata,
    input wire                    o_rsp_illegal,
    input wire                    o_seteip_ready,
    input wire [2:0]              o_irq,
    input imsic_file_pkg::topei_t o_mtopei,
    input imsic_file_pkg::topei_t o_stopei,
    input imsic_file_pkg::topei_t o_vstopei
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned n_fail = 0;  // failed checks so far

    // a stalled response keeps its payload
    a_rsp_held: assert property (@(posedge clk) disable iff (!rstn)
        o_rsp_vld && !i_rsp_ready |=> o_rsp_vld && $stable(o_rsp_rdata) && $stable(o_rsp_illegal))
    else begin
        n_fail = n_fail + 1;
        $error("held response changed before it was accepted");
    end

    a_no_accept: assert property (@(posedge clk) disable iff (!rstn)
        o_rsp_vld && !i_rsp_ready |-> !(i_csr_vld && o_csr_ready))
    else begin
        n_fail = n_fail + 1;
        $error("csr request accepted while a response was still held");
    end

    // idle outputs while reset is low
    a_reset_quiet: assert property (@(posedge clk)
        !rstn |-> !o_rsp_vld && o_csr_ready && o_seteip_ready && (o_irq == '0)
                  && (o_mtopei == '0) && (o_stopei == '0) && (o_vstopei == '0))
    else begin
        n_fail = n_fail + 1;
        $error("outputs not at their reset values during reset");
    end

endmodule

bind imsic_top imsic_asserts u_asserts (
    .clk            (clk),
    .rstn           (rstn),
    .i_csr_vld      (i_csr_vld),
    .i_rsp_ready    (i_rsp_ready),
    .o_csr_ready    (o_csr_ready),
    .o_rsp_vld      (o_rsp_vld),
    .o_rsp_rdata    (o_rsp_rdata),
    .o_rsp_illegal  (o_rsp_illegal),
    .o_seteip_ready (o_seteip_ready),
    .o_irq          (o_irq),
    .o_mtopei       (o_mtopei),
    .o_stopei       (o_stopei),
    .o_vstopei      (o_vstopei)
);

`default_nettype wire

//--- tests/tb_imsic_top.sv
// expected values assume IMSIC_NR_FILES of 4 and the imsic_asserts checker bound into imsic_top
`default_nettype none

module tb_imsic_top;
    timeunit 1ns;
    timeprecision 1ps;

    import imsic_csr_pkg::*;
    import imsic_file_pkg::*;

    localparam int          CLK_PERIOD = 100;
    localparam int          SETTLE     = 25;      // sample point after the falling edge
    localparam logic [11:0] EIP0       = 12'h080;
    localparam logic [11:0] EIE0       = 12'h0c0;
    localparam logic [11:0] IPRIO0     = 12'h030;
    localparam xlen_t       EIE3       = 64'hf0f0_0000_1234_5678;

    typedef enum logic [1:0] {OP_CSR, OP_SET, OP_CHK} op_e;

    typedef struct packed {
        op_e         op;
        logic        we;
        logic [11:0] addr;
        file_idx_t   file;
        logic        v;
        logic        perr;
        xlen_t       wdata;
        xlen_t       rdata;   // expected read data
        logic        ill;     // expected illegal flag
        logic [5:0]  num;     // seteip identity or vgein of a check
        logic [2:0]  irq;
        intr_id_t    mid;
        intr_id_t    sid;
        intr_id_t    vid;
    } step_t;

    logic      clk;
    logic      rstn;
    logic      i_csr_vld;
    logic      i_csr_we;
    csr_addr_u i_csr_addr;
    xlen_t     i_csr_wdata;
    file_idx_t i_csr_file;
    logic      i_csr_v;
    logic      i_csr_priv_err;
    logic      o_csr_ready;
    logic      o_rsp_vld;
    xlen_t     o_rsp_rdata;
    logic      o_rsp_illegal;
    logic      i_rsp_ready;
    logic      i_seteip_vld;
    file_idx_t i_seteip_file;
    intr_id_t  i_seteip_num;
    logic      o_seteip_ready;
    logic [5:0] i_vgein;
    logic [2:0] o_irq;
    topei_t    o_mtopei;
    topei_t    o_stopei;
    topei_t    o_vstopei;

    step_t       steps[$];
    xlen_t       exp_rdata_q[$];
    logic        exp_ill_q[$];
    int          exp_row_q[$];
    logic [31:0] lcg_state;

    imsic_top uut (
        .clk(clk), .rstn(rstn),
        .i_csr_vld(i_csr_vld), .i_csr_we(i_csr_we), .i_csr_addr(i_csr_addr),
        .i_csr_wdata(i_csr_wdata), .i_csr_file(i_csr_file), .i_csr_v(i_csr_v),
        .i_csr_priv_err(i_csr_priv_err), .o_csr_ready(o_csr_ready),
        .o_rsp_vld(o_rsp_vld), .o_rsp_rdata(o_rsp_rdata), .o_rsp_illegal(o_rsp_illegal),
        .i_rsp_ready(i_rsp_ready), .i_seteip_vld(i_seteip_vld),
        .i_seteip_file(i_seteip_file), .i_seteip_num(i_seteip_num),
        .o_seteip_ready(o_seteip_ready), .i_vgein(i_vgein), .o_irq(o_irq),
        .o_mtopei(o_mtopei), .o_stopei(o_stopei), .o_vstopei(o_vstopei)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic step_t csr_row(input logic we, input logic [11:0] addr,
                                      input file_idx_t file, input logic v, input logic perr,
                                      input xlen_t wdata, input xlen_t rdata, input logic ill);
        step_t s;
        s       = '0;
        s.op    = OP_CSR;
        s.we    = we;
        s.addr  = addr;
        s.file  = file;
        s.v     = v;
        s.perr  = perr;
        s.wdata = wdata;
        s.rdata = rdata;
        s.ill   = ill;
        return s;
    endfunction

    function automatic step_t seteip_row(input file_idx_t file, input intr_id_t num);
        step_t s;
        s      = '0;
        s.op   = OP_SET;
        s.file = file;
        s.num  = num;
        return s;
    endfunction

    function automatic step_t check_row(input logic [5:0] vgein, input logic [2:0] irq,
                                        input intr_id_t mid, input intr_id_t sid,
                                        input intr_id_t vid);
        step_t s;
        s     = '0;
        s.op  = OP_CHK;
        s.num = vgein;
        s.irq = irq;
        s.mid = mid;
        s.sid = sid;
        s.vid = vid;
        return s;
    endfunction

    // identity in 26:16 and priority equal to it in 10:0
    function automatic topei_t expected_topei(input intr_id_t id);
        return (32'(id) << 16) | 32'(id);
    endfunction

    function automatic logic draw_rsp_ready();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[17:16] != 2'b00;   // ready three times in four
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERROR %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bound_asserts();
        assert (uut.u_asserts.n_fail == 0) else begin
            $display("a bound assertion on imsic_top failed before %0t ns", $time);
            abort_run();
        end
    endtask

    task automatic check_response();
        int row;
        assert (exp_row_q.size() != 0) else begin
            $display("a response was handed over at %0t ns with no request outstanding", $time);
            abort_run();
        end
        row = exp_row_q.pop_front();
        check_value($sformatf("o_rsp_rdata row %0d", row), o_rsp_rdata, exp_rdata_q.pop_front());
        check_value($sformatf("o_rsp_illegal row %0d", row), o_rsp_illegal, exp_ill_q.pop_front());
    endtask

    // one cycle from falling edge to falling edge with a random consumer
    task automatic tick(output logic req_taken);
        i_rsp_ready = draw_rsp_ready();
        #(SETTLE);
        req_taken = i_csr_vld && o_csr_ready;
        if (o_rsp_vld && i_rsp_ready) begin
            check_response();
        end
        if (o_rsp_vld && !i_rsp_ready) begin
            check_value("o_csr_ready", o_csr_ready, 0);
        end
        if (i_seteip_vld) begin
            check_value("o_seteip_ready", o_seteip_ready, 1);   // no eip write in flight
        end
        check_bound_asserts();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic drain_responses();
        logic taken;
        while (exp_row_q.size() != 0) begin
            tick(taken);
        end
    endtask

    task automatic run_csr(input step_t s, input int row);
        logic taken;
        i_csr_vld      = 1'b1;
        i_csr_we       = s.we;
        i_csr_addr.raw = s.addr;
        i_csr_wdata    = s.wdata;
        i_csr_file     = s.file;
        i_csr_v        = s.v;
        i_csr_priv_err = s.perr;
        taken          = 1'b0;
        while (!taken) begin
            tick(taken);
        end
        exp_rdata_q.push_back(s.rdata);
        exp_ill_q.push_back(s.ill);
        exp_row_q.push_back(row);
        i_csr_vld = 1'b0;
    endtask

    task automatic run_seteip(input step_t s);
        logic taken;
        i_seteip_vld  = 1'b1;
        i_seteip_file = s.file;
        i_seteip_num  = s.num;
        tick(taken);
        i_seteip_vld  = 1'b0;
    endtask

    // the registered search result needs two edges after any change
    task automatic run_check(input step_t s, input int row);
        logic taken;
        drain_responses();
        i_vgein = s.num;
        tick(taken);
        tick(taken);
        check_value($sformatf("o_irq row %0d", row), o_irq, s.irq);
        check_value($sformatf("o_mtopei row %0d", row), o_mtopei, expected_topei(s.mid));
        check_value($sformatf("o_stopei row %0d", row), o_stopei, expected_topei(s.sid));
        check_value($sformatf("o_vstopei row %0d", row), o_vstopei, expected_topei(s.vid));
    endtask

    task automatic build_table();
        // config registers written and read back
        steps.push_back(csr_row(1, EITHRESHOLD_ADDR, 0, 0, 0, 64'h0a, 64'h0, 0));
        steps.push_back(csr_row(0, EITHRESHOLD_ADDR, 0, 0, 0, 64'h0, 64'h0a, 0));
        steps.push_back(csr_row(1, EIDELIVERY_ADDR, 2, 0, 0, 64'h1, 64'h0, 0));
        steps.push_back(csr_row(0, EIDELIVERY_ADDR, 2, 0, 0, 64'h0, 64'h1, 0));
        steps.push_back(csr_row(1, EIE0, 3, 0, 0, EIE3, 64'h0, 0));
        steps.push_back(csr_row(0, EIE0, 3, 0, 0, 64'h0, EIE3, 0));
        steps.push_back(csr_row(1, EIP0, 0, 0, 0, 64'hff, 64'h0, 0));
        steps.push_back(csr_row(0, EIP0, 0, 0, 0, 64'h0, 64'hfe, 0));   // id 0 never pending
        steps.push_back(csr_row(0, EIE0, 0, 0, 0, 64'h0, 64'h0, 0));
        // illegal accesses and then a readback of the unchanged state
        steps.push_back(csr_row(1, 12'h081, 0, 0, 0, 64'hffff, 64'h0, 1));   // odd eip
        steps.push_back(csr_row(1, 12'h0c2, 3, 0, 0, '1, 64'h0, 1));          // eie index 1
        steps.push_back(csr_row(0, IPRIO0, 0, 1, 0, 64'h0, 64'h0, 1));
        steps.push_back(csr_row(1, EITHRESHOLD_ADDR, 0, 0, 1, 64'h3, 64'h0, 1));
        steps.push_back(csr_row(0, 12'h100, 0, 0, 0, 64'h0, 64'h0, 1));       // unknown
        steps.push_back(csr_row(0, IPRIO0, 0, 0, 0, 64'h0, 64'h0, 0));
        steps.push_back(csr_row(1, IPRIO0, 0, 0, 0, 64'h55, 64'h0, 0));
        steps.push_back(csr_row(0, EIP0, 0, 0, 0, 64'h0, 64'hfe, 0));
        steps.push_back(csr_row(0, EIE0, 3, 0, 0, 64'h0, EIE3, 0));
        steps.push_back(csr_row(0, EITHRESHOLD_ADDR, 0, 0, 0, 64'h0, 64'h0a, 0));
        // msis into the supervisor file
        steps.push_back(check_row(0, 3'b000, 0, 0, 0));
        steps.push_back(csr_row(1, EIE0, 1, 0, 0, 64'h220, 64'h0, 0));        // ids 5 and 9
        steps.push_back(csr_row(1, EIDELIVERY_ADDR, 1, 0, 0, 64'h1, 64'h0, 0));
        steps.push_back(seteip_row(1, 9));
        steps.push_back(seteip_row(1, 5));
        steps.push_back(seteip_row(1, 0));
        steps.push_back(check_row(0, 3'b010, 0, 5, 0));
        steps.push_back(csr_row(0, EIP0, 1, 0, 0, 64'h0, 64'h220, 0));
        // threshold and then delivery off
        steps.push_back(csr_row(1, EITHRESHOLD_ADDR, 1, 0, 0, 64'h5, 64'h0, 0));
        steps.push_back(check_row(0, 3'b000, 0, 0, 0));
        steps.push_back(csr_row(1, EITHRESHOLD_ADDR, 1, 0, 0, 64'h6, 64'h0, 0));
        steps.push_back(check_row(0, 3'b010, 0, 5, 0));
        steps.push_back(csr_row(1, EIDELIVERY_ADDR, 1, 0, 0, 64'h0, 64'h0, 0));
        steps.push_back(check_row(0, 3'b000, 0, 5, 0));
        // guest file 3 picked by vgein 1 while vgein 2 is past the last guest
        steps.push_back(csr_row(1, EIDELIVERY_ADDR, 3, 0, 0, 64'h1, 64'h0, 0));
        steps.push_back(seteip_row(3, 4));
        steps.push_back(check_row(1, 3'b100, 0, 5, 4));
        steps.push_back(check_row(2, 3'b000, 0, 5, 0));
        steps.push_back(csr_row(0, EIP0, 3, 0, 0, 64'h0, 64'h10, 0));
        steps.push_back(csr_row(1, EIP0, 3, 0, 0, 64'h0, 64'h0, 0));
        steps.push_back(check_row(1, 3'b000, 0, 5, 0));
        // machine file with ids 1 to 7 pending and 3 and 6 enabled
        steps.push_back(csr_row(1, EIE0, 0, 0, 0, 64'h48, 64'h0, 0));
        steps.push_back(csr_row(1, EIDELIVERY_ADDR, 0, 0, 0, 64'h1, 64'h0, 0));
        steps.push_back(check_row(1, 3'b001, 3, 5, 0));
    endtask

    initial begin
        lcg_state      = 32'd50;
        rstn           = 1'b0;
        i_csr_vld      = 1'b0;
        i_csr_we       = 1'b0;
        i_csr_addr.raw = '0;
        i_csr_wdata    = '0;
        i_csr_file     = '0;
        i_csr_v        = 1'b0;
        i_csr_priv_err = 1'b0;
        i_rsp_ready    = 1'b1;
        i_seteip_vld   = 1'b0;
        i_seteip_file  = '0;
        i_seteip_num   = '0;
        i_vgein        = '0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        for (int k = 0; k < steps.size(); k++) begin
            case (steps[k].op)
                OP_CSR:  run_csr(steps[k], k);
                OP_SET:  run_seteip(steps[k]);
                default: run_check(steps[k], k);
            endcase
        end
        drain_responses();
        check_value("o_rsp_vld", o_rsp_vld, 0);
        check_bound_asserts();
        $display("Simulation passed");
        $finish;
    end

    // twenty cycles per table row
    initial begin
        #1;
        #(steps.size() * 20 * CLK_PERIOD);
        $display("timeout: the step table did not finish within %0d cycles", steps.size() * 20);
        abort_run();
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+src
src/imsic_csr_pkg.sv
src/imsic_file_pkg.sv
src/imsic_csr_access.sv
src/imsic_pending.sv
src/imsic_topei_select.sv
src/imsic_top.sv
tests/imsic_asserts.sv
tests/tb_imsic_top.sv

//--- Bender.yml
package:
  name: imsic_file

sources:
  - include_dirs:
      - src
    files:
      - src/imsic_csr_pkg.sv
      - src/imsic_file_pkg.sv
      - src/imsic_csr_access.sv
      - src/imsic_pending.sv
      - src/imsic_topei_select.sv
      - src/imsic_top.sv
  - target: test
    files:
      - tests/imsic_asserts.sv
      - tests/tb_imsic_top.sv
